// ==== compile.f ====
+incdir+testbench
rtl/stack_instr_pkg.sv
rtl/alu_op_decode.sv
rtl/mem_stack_decode.sv
rtl/instr_dec.sv
testbench/tb_instr_dec.sv

// ==== Makefile ====
# Verilator build for the instruction decoder

VERILATOR   = verilator
LINT_FLAGS  = --lint-only --timing
SIM_FLAGS   = --binary --timing --assert -j 0
TOP         = tb_instr_dec
FILELIST    = compile.f
BUILD_DIR   = obj_dir
PASS_TEXT   = *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	status=$$?; \
	echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

// ==== testbench/decode_model.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Opcodes 0..88 that survive, the rest of that range is floating point
function automatic bit is_kept_opcode(input int op);
	return (op >= 0 && op <= 47) || (op >= 49 && op <= 53) || op == 59 || op == 60
		|| op == 64 || op == 77 || op == 78 || op == 82 || op == 83 || op == 87 || op == 88;
endfunction

// ALU code one cycle after the opcode
function automatic logic [5:0] alu_code_for(input int op);
	case (op)
		0, 1, 3, 10, 50, 52, 64:      return alu_load;
		13, 14:                       return alu_add;
		15, 16:                       return alu_mult;
		17, 18:                       return alu_div;
		19, 20:                       return alu_mod;
		21, 22:                       return alu_and;
		23, 24:                       return alu_land;
		25, 26:                       return alu_or;
		27, 28:                       return alu_lor;
		29, 30:                       return alu_xor;
		33, 34:                       return alu_equ;
		35, 36:                       return alu_gre;
		37, 38:                       return alu_les;
		39, 40:                       return alu_shr;
		41, 42:                       return alu_shl;
		43, 44:                       return alu_srs;
		12:                           return alu_neg;
		31:                           return alu_inv;
		32:                           return alu_linv;
		45:                           return alu_pst;
		47:                           return alu_nrm;
		49:                           return alu_abs;
		46, 51:                       return alu_sign;
		59, 60:                       return alu_negm;
		77, 78:                       return alu_absm;
		82, 83:                       return alu_pstm;
		87, 88:                       return alu_nrmm;
		default:                      return alu_none;  // Includes stores, jumps and I/O
	endcase
endfunction

// Registered flags as {srf, srf_invert, req_in, out_en}
function automatic logic [3:0] reg_flags_for(input int op);
	return {op == 9 || op == 53, op == 53, op == 10, op == 11};
endfunction

// Same cycle flags as {mem_wr, dsp_push, dsp_pop, ldi, ldi_invert}
function automatic logic [4:0] mem_stack_flags_for(input int op);
	logic push;
	logic wr;
	logic pop;
	push = op == 1 || op == 4 || op == 60 || op == 78 || op == 83 || op == 88;
	wr   = push || op == 2 || op == 3;
	pop  = op == 3 || op == 9 || op == 11 || op == 53 || op == 64 || op == 46
		|| (op >= 14 && op <= 44 && op % 2 == 0 && op != 32);  // 32 is LINV, no stack operand
	return {wr, push, pop, op == 50 || op == 52, op == 50};
endfunction

`endif

// ==== testbench/tb_instr_dec.sv ====
`timescale 1ns/100ps

module tb_instr_dec
	import stack_instr_pkg::*;
;

	logic      clk;
	logic      rst;
	opcode_t   opcode;
	operand_t  operand;
	data_t     mem_data_in;
	data_t     io_in;
	alu_op_e   ula_op;
	data_t     ula_data;
	mem_addr_t mem_addr;
	logic      mem_wr, dsp_push, dsp_pop, ldi, srf, req_in, out_en, inv;

	int          errors;
	int          timeouts;
	int          checks;
	int          kept_ops[$];
	int          dropped_ops[$];
	logic [5:0]  prev_alu;   // Expected registered values for the coming check
	logic [3:0]  prev_reg;

	`include "decode_model.svh"

	instr_dec dut0 (
		.clk(clk), .rst(rst), .opcode(opcode), .operand(operand),
		.mem_data_in(mem_data_in), .io_in(io_in), .ula_op(ula_op), .ula_data(ula_data),
		.mem_addr(mem_addr), .mem_wr(mem_wr), .dsp_push(dsp_push), .dsp_pop(dsp_pop),
		.ldi(ldi), .srf(srf), .req_in(req_in), .out_en(out_en), .inv(inv)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERR %0d ns: %s is %0h, expected %0h, opcode %0d", $time, what, got, exp,
				opcode);
		end
	endtask

	// Mostly kept opcodes, some unused and some float ones
	function automatic opcode_t pick_opcode();
		int r;
		r = $urandom_range(0, 9);
		if (r < 7)
			return opcode_t'(kept_ops[$urandom_range(0, kept_ops.size() - 1)]);
		else if (r == 7)
			return opcode_t'($urandom_range(89, 127));
		return opcode_t'(dropped_ops[$urandom_range(0, dropped_ops.size() - 1)]);
	endfunction

	task automatic run_cycle(input logic rst_level, input opcode_t op);
		logic [5:0] exp_alu;
		logic [3:0] exp_reg;
		logic [4:0] exp_comb;
		@(posedge clk);
		#1;
		rst         = rst_level;
		opcode      = op;
		operand     = operand_t'($urandom);
		mem_data_in = $urandom;
		io_in       = $urandom;
		@(negedge clk);  // All outputs settled here
		exp_comb = mem_stack_flags_for(int'(op));
		exp_alu  = rst ? 6'd0 : prev_alu;
		exp_reg  = rst ? 4'd0 : prev_reg;
		check_value("ula_op", ula_op, exp_alu);
		check_value("srf", srf, exp_reg[3]);
		check_value("req_in", req_in, exp_reg[1]);
		check_value("out_en", out_en, exp_reg[0]);
		check_value("mem_wr", mem_wr, exp_comb[4]);
		check_value("dsp_push", dsp_push, exp_comb[3]);
		check_value("dsp_pop", dsp_pop, exp_comb[2]);
		check_value("ldi", ldi, exp_comb[1]);
		check_value("inv", inv, exp_reg[2] | exp_comb[0]);  // Last ISRF or current ILDI
		check_value("mem_addr", mem_addr, operand[7:0]);
		check_value("ula_data", ula_data, exp_reg[1] ? io_in : mem_data_in);
		prev_alu = rst ? 6'd0 : alu_code_for(int'(op));
		prev_reg = rst ? 4'd0 : reg_flags_for(int'(op));
	endtask

	// Registered outputs must come out of reset within a few edges
	task automatic wait_reset_state(output bit ok);
		ok = 1'b0;
		for (int i = 0; i < 4 && !ok; i++) begin
			@(negedge clk);
			ok = (ula_op == alu_none) && !srf && !req_in && !out_en;
		end
	endtask

	initial begin
		bit          reset_ok;
		void'($urandom(32'heebb));
		rst         = 1'b1;
		opcode      = '0;
		operand     = '0;
		mem_data_in = '0;
		io_in       = '0;
		errors      = 0;
		timeouts    = 0;
		checks      = 0;
		prev_alu    = '0;
		prev_reg    = '0;
		for (int i = 0; i <= 88; i++) begin
			if (is_kept_opcode(i))
				kept_ops.push_back(i);
			else
				dropped_ops.push_back(i);
		end

		wait_reset_state(reset_ok);
		if (reset_ok) begin
			repeat (8) run_cycle(1'b1, pick_opcode());  // Random opcodes while in reset
			for (int i = 0; i < 128; i++)
				run_cycle(1'b0, opcode_t'(i));
			for (int i = 0; i < 4; i++) begin  // ISRF and ILDI back to back, both orders
				run_cycle(1'b0, op_isrf);
				run_cycle(1'b0, op_ildi);
				run_cycle(1'b0, op_ildi);
				run_cycle(1'b0, op_isrf);
			end
			repeat (600) run_cycle(1'b0, pick_opcode());
		end else begin
			timeouts++;
			$display("Timeout: decoder outputs never reached their reset values");
		end

		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== rtl/instr_dec.sv ====
`timescale 1ns/100ps

module instr_dec
	import stack_instr_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  opcode_t   opcode,
	input  operand_t  operand,
	input  data_t     mem_data_in,
	input  data_t     io_in,
	output alu_op_e   ula_op,
	output data_t     ula_data,
	output mem_addr_t mem_addr,
	output logic      mem_wr,
	output logic      dsp_push,
	output logic      dsp_pop,
	output logic      ldi,
	output logic      srf,
	output logic      req_in,
	output logic      out_en,
	output logic      inv
);

	logic srf_invert;  // Registered, from the previous opcode
	logic ldi_invert;  // Combinational, from the current opcode

	alu_op_decode u_alu_op_decode (
		.clk        (clk),
		.rst        (rst),
		.opcode     (opcode),
		.ula_op     (ula_op),
		.srf        (srf),
		.srf_invert (srf_invert),
		.req_in     (req_in),
		.out_en     (out_en)
	);

	mem_stack_decode u_mem_stack_decode (
		.opcode     (opcode),
		.mem_wr     (mem_wr),
		.dsp_push   (dsp_push),
		.dsp_pop    (dsp_pop),
		.ldi        (ldi),
		.ldi_invert (ldi_invert)
	);

	assign inv      = srf_invert | ldi_invert;
	assign ula_data = req_in ? io_in : mem_data_in;   // IN loads the port a cycle later
	assign mem_addr = operand[mem_addr_width-1:0];

endmodule

// ==== rtl/mem_stack_decode.sv ====
`timescale 1ns/100ps

module mem_stack_decode
	import stack_instr_pkg::*;
(
	input  opcode_t opcode,
	output logic    mem_wr,
	output logic    dsp_push,
	output logic    dsp_pop,
	output logic    ldi,
	output logic    ldi_invert
);

	always_comb begin
		mem_wr     = 1'b0;
		dsp_push   = 1'b0;
		dsp_pop    = 1'b0;
		ldi        = 1'b0;
		ldi_invert = 1'b0;

		case (opcode)
			// Accumulator goes to the stack top before the operation
			op_pld, op_push, op_pnegm, op_pabsm, op_ppstm, op_pnrmm: begin
				mem_wr   = 1'b1;
				dsp_push = 1'b1;
			end

			op_set:
				mem_wr = 1'b1;
			op_setp: begin                 // Stores a call parameter
				mem_wr  = 1'b1;
				dsp_pop = 1'b1;
			end

			op_srf, op_out, op_isrf, op_pop:
				dsp_pop = 1'b1;

			// Binary ops taking the second operand from the stack
			op_sadd, op_smlt, op_sdiv, op_smod, op_sand, op_sland:
				dsp_pop = 1'b1;
			op_sor, op_slor, op_sxor, op_sequ, op_sgre, op_sles:
				dsp_pop = 1'b1;
			op_sshr, op_sshl, op_ssrs, op_ssign:
				dsp_pop = 1'b1;
			// LINV sits at 32 among the stack forms but is unary

			op_ildi: begin
				ldi        = 1'b1;
				ldi_invert = 1'b1;
			end
			op_ldi:
				ldi = 1'b1;

			default: ;                     // Float and unused opcodes are no-ops
		endcase

		if (!$isunknown(opcode)) begin
			a_push_pop: assert (!(dsp_push && dsp_pop))
				else $error("push and pop decoded together, opcode %0d", opcode);
			// A push always writes the accumulator into the top memory word
			a_push_wr: assert (!dsp_push || mem_wr)
				else $error("push without mem_wr, opcode %0d", opcode);
			a_ldi_inv: assert (!ldi_invert || ldi)
				else $error("ldi_invert without ldi, opcode %0d", opcode);
		end
	end

endmodule

// ==== rtl/alu_op_decode.sv ====
`timescale 1ns/100ps

module alu_op_decode
	import stack_instr_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  opcode_t opcode,
	output alu_op_e ula_op,
	output logic    srf,
	output logic    srf_invert,
	output logic    req_in,
	output logic    out_en
);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ula_op     <= alu_none;
			srf        <= 1'b0;
			srf_invert <= 1'b0;
			req_in     <= 1'b0;
			out_en     <= 1'b0;
		end else begin
			srf        <= (opcode == op_srf) || (opcode == op_isrf);
			srf_invert <= (opcode == op_isrf);  // ISRF writes the inverted word
			req_in     <= (opcode == op_in);
			out_en     <= (opcode == op_out);

			case (opcode)
				// Loads, the data source is chosen at the top level
				op_load, op_pld, op_setp, op_in, op_ildi, op_ldi, op_pop:
					ula_op <= alu_load;

				// Control flow and stores leave the accumulator alone
				op_set, op_push, op_jz, op_jmp, op_call, op_return:
					ula_op <= alu_none;
				op_srf, op_out, op_isrf:
					ula_op <= alu_none;

				op_add, op_sadd:   ula_op <= alu_add;
				op_mlt, op_smlt:   ula_op <= alu_mult;
				op_div, op_sdiv:   ula_op <= alu_div;
				op_mod, op_smod:   ula_op <= alu_mod;
				op_and, op_sand:   ula_op <= alu_and;
				op_land, op_sland: ula_op <= alu_land;
				op_or, op_sor:     ula_op <= alu_or;
				op_lor, op_slor:   ula_op <= alu_lor;
				op_xor, op_sxor:   ula_op <= alu_xor;
				op_equ, op_sequ:   ula_op <= alu_equ;
				op_gre, op_sgre:   ula_op <= alu_gre;
				op_les, op_sles:   ula_op <= alu_les;
				op_shr, op_sshr:   ula_op <= alu_shr;
				op_shl, op_sshl:   ula_op <= alu_shl;
				op_srs, op_ssrs:   ula_op <= alu_srs;

				// Unary operations on the accumulator
				op_neg:            ula_op <= alu_neg;
				op_inv:            ula_op <= alu_inv;
				op_linv:           ula_op <= alu_linv;
				op_pst:            ula_op <= alu_pst;
				op_nrm:            ula_op <= alu_nrm;
				op_abs:            ula_op <= alu_abs;
				op_sign, op_ssign: ula_op <= alu_sign;  // Sign of in1 applied to in2

				// Unary operations on a memory word
				op_negm, op_pnegm: ula_op <= alu_negm;
				op_absm, op_pabsm: ula_op <= alu_absm;
				op_pstm, op_ppstm: ula_op <= alu_pstm;
				op_nrmm, op_pnrmm: ula_op <= alu_nrmm;

				default:           ula_op <= alu_none;  // Float and unused opcodes
			endcase
		end
	end

	// IN and OUT are separate instructions, the I/O port is never both ways
	a_io_exclusive: assert property (
		@(posedge clk) disable iff (rst)
		!(req_in && out_en)
	) else $error("req_in and out_en high together");

	a_invert_needs_srf: assert property (
		@(posedge clk) disable iff (rst)
		srf_invert |-> srf
	) else $error("srf_invert without srf");

endmodule

// ==== rtl/stack_instr_pkg.sv ====
package stack_instr_pkg;

	localparam int data_width     = 32; // Accumulator, memory and I/O data
	localparam int opcode_width   = 7;
	localparam int operand_width  = 9;
	localparam int mem_addr_width = 8;  // Data memory depth is 256 words
	localparam int alu_op_width   = 6;

	typedef logic [data_width-1:0]     data_t;
	typedef logic [opcode_width-1:0]   opcode_t;
	typedef logic [operand_width-1:0]  operand_t;
	typedef logic [mem_addr_width-1:0] mem_addr_t;

	// Instruction set, the S prefix marks the stack operand form
	typedef enum opcode_t {
		op_load   = 7'd0,  op_pld    = 7'd1,  op_set    = 7'd2,  op_setp   = 7'd3,
		op_push   = 7'd4,  op_jz     = 7'd5,  op_jmp    = 7'd6,  op_call   = 7'd7,
		op_return = 7'd8,  op_srf    = 7'd9,  op_in     = 7'd10, op_out    = 7'd11,
		op_neg    = 7'd12, op_add    = 7'd13, op_sadd   = 7'd14, op_mlt    = 7'd15,
		op_smlt   = 7'd16, op_div    = 7'd17, op_sdiv   = 7'd18, op_mod    = 7'd19,
		op_smod   = 7'd20, op_and    = 7'd21, op_sand   = 7'd22, op_land   = 7'd23,
		op_sland  = 7'd24, op_or     = 7'd25, op_sor    = 7'd26, op_lor    = 7'd27,
		op_slor   = 7'd28, op_xor    = 7'd29, op_sxor   = 7'd30, op_inv    = 7'd31,
		op_linv   = 7'd32, op_equ    = 7'd33, op_sequ   = 7'd34, op_gre    = 7'd35,
		op_sgre   = 7'd36, op_les    = 7'd37, op_sles   = 7'd38, op_shr    = 7'd39,
		op_sshr   = 7'd40, op_shl    = 7'd41, op_sshl   = 7'd42, op_srs    = 7'd43,
		op_ssrs   = 7'd44, op_pst    = 7'd45, op_ssign  = 7'd46, op_nrm    = 7'd47,
		op_abs    = 7'd49, // 48 was a float conversion
		op_ildi   = 7'd50, // Indirect load with inverted address bits
		op_sign   = 7'd51,
		op_ldi    = 7'd52, // Indirect load, offset in the accumulator
		op_isrf   = 7'd53, // Register file set with inverted bits
		op_negm   = 7'd59,
		op_pnegm  = 7'd60, // P prefix pushes the accumulator first
		op_pop    = 7'd64,
		op_absm   = 7'd77,
		op_pabsm  = 7'd78,
		op_pstm   = 7'd82,
		op_ppstm  = 7'd83,
		op_nrmm   = 7'd87,
		op_pnrmm  = 7'd88
	} instr_op_e;

	// ALU operation codes, the float codes in between are unused
	typedef enum logic [alu_op_width-1:0] {
		alu_none = 6'd0,
		alu_load = 6'd1,
		alu_add  = 6'd2,
		alu_mult = 6'd3,
		alu_div  = 6'd4,
		alu_mod  = 6'd5,
		alu_neg  = 6'd6,  // Two's complement
		alu_nrm  = 6'd7,  // Divide by a constant
		alu_abs  = 6'd8,
		alu_pst  = 6'd9,  // Value or zero when negative
		alu_sign = 6'd10,
		alu_or   = 6'd11,
		alu_and  = 6'd12,
		alu_inv  = 6'd13,
		alu_xor  = 6'd14,
		alu_les  = 6'd15,
		alu_gre  = 6'd16,
		alu_equ  = 6'd17,
		alu_linv = 6'd18, // Logical not
		alu_land = 6'd19,
		alu_lor  = 6'd20,
		alu_shl  = 6'd21,
		alu_shr  = 6'd22,
		alu_srs  = 6'd23, // Arithmetic shift right
		alu_negm = 6'd28,
		alu_absm = 6'd37,
		alu_pstm = 6'd40,
		alu_nrmm = 6'd43
	} alu_op_e;

endpackage
